/* include/blur_macros.svh */
// Gaussian blur image parameters
`ifndef BLUR_MACROS_SVH
`define BLUR_MACROS_SVH

// active image size, kept small for simulation
`define BLUR_IMG_WIDTH 16
`define BLUR_IMG_HEIGHT 12

// colour channels per pixel (R, G, B)
`define BLUR_CHANNELS 3

// bits per colour channel
`define BLUR_CHAN_WIDTH 8

`endif

/* rtl/blur_pkg.sv */
// Gaussian blur types
`include "blur_macros.svh"

package blur_pkg;

    // one colour sample
    typedef logic [`BLUR_CHAN_WIDTH-1:0] chan_t;

    // red in the top byte, then green, then blue
    typedef logic [`BLUR_CHANNELS*`BLUR_CHAN_WIDTH-1:0] pixel_t;

    // three neighbouring samples of one channel, leftmost in the top byte
    typedef logic [3*`BLUR_CHAN_WIDTH-1:0] row3_t;

    // raster position counters
    typedef logic [$clog2(`BLUR_IMG_WIDTH)-1:0] col_t;
    typedef logic [$clog2(`BLUR_IMG_HEIGHT)-1:0] line_t;

    // output pixels per frame, 14 x 10 interior pixels
    typedef logic [7:0] count_t;

endpackage

/* rtl/window_gen.sv */
// 3x3 window generator
`timescale 1ns/1ps
`include "blur_macros.svh"

module window_gen (
    input  logic             clk_in,
    input  logic             rst_in,
    input  blur_pkg::pixel_t pixel_in,
    input  logic             pixel_valid_in,
    output blur_pkg::row3_t  r0_out [`BLUR_CHANNELS],
    output blur_pkg::row3_t  r1_out [`BLUR_CHANNELS],
    output blur_pkg::row3_t  r2_out [`BLUR_CHANNELS],
    output logic             window_valid_out
);

    localparam int W = `BLUR_CHAN_WIDTH;

    // line_buf_1 holds the previous line, line_buf_2 the one before it
    blur_pkg::pixel_t line_buf_1 [`BLUR_IMG_WIDTH];
    blur_pkg::pixel_t line_buf_2 [`BLUR_IMG_WIDTH];

    // stored pixels directly above the incoming one
    blur_pkg::pixel_t above_1;
    blur_pkg::pixel_t above_2;

    // window rows top to bottom with index 0 as the leftmost column
    blur_pkg::pixel_t win_top [3];
    blur_pkg::pixel_t win_mid [3];
    blur_pkg::pixel_t win_bot [3];

    blur_pkg::col_t  col_cnt;
    blur_pkg::line_t line_cnt;
    logic            last_col;
    logic            last_line;
    logic            interior;

    assign above_1   = line_buf_1[col_cnt];
    assign above_2   = line_buf_2[col_cnt];
    assign last_col  = (col_cnt == blur_pkg::col_t'(`BLUR_IMG_WIDTH - 1));
    assign last_line = (line_cnt == blur_pkg::line_t'(`BLUR_IMG_HEIGHT - 1));

    // a full 3x3 neighbourhood needs two earlier columns and two earlier lines
    assign interior = (col_cnt >= blur_pkg::col_t'(2)) && (line_cnt >= blur_pkg::line_t'(2));

    // raster position advances once per accepted pixel
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            col_cnt  <= '0;
            line_cnt <= '0;
        end else if (pixel_valid_in) begin
            if (last_col) begin
                col_cnt  <= '0;
                line_cnt <= last_line ? '0 : line_cnt + blur_pkg::line_t'(1);
            end else begin
                col_cnt <= col_cnt + blur_pkg::col_t'(1);
            end
        end
    end

    // each column moves one line down through the buffers
    always_ff @(posedge clk_in) begin
        if (pixel_valid_in) begin
            line_buf_2[col_cnt] <= above_1;
            line_buf_1[col_cnt] <= pixel_in;
        end
    end

    // shift the new column in from the right
    always_ff @(posedge clk_in) begin
        if (pixel_valid_in) begin
            win_top[0] <= win_top[1];
            win_top[1] <= win_top[2];
            win_top[2] <= above_2;

            win_mid[0] <= win_mid[1];
            win_mid[1] <= win_mid[2];
            win_mid[2] <= above_1;

            win_bot[0] <= win_bot[1];
            win_bot[1] <= win_bot[2];
            win_bot[2] <= pixel_in;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            window_valid_out <= 1'b0;
        end else begin
            window_valid_out <= pixel_valid_in && interior;
        end
    end

    // split every window row into its colour channels
    always_comb begin
        for (int c = 0; c < `BLUR_CHANNELS; c++) begin
            r0_out[c] = {win_top[0][c*W +: W], win_top[1][c*W +: W], win_top[2][c*W +: W]};
            r1_out[c] = {win_mid[0][c*W +: W], win_mid[1][c*W +: W], win_mid[2][c*W +: W]};
            r2_out[c] = {win_bot[0][c*W +: W], win_bot[1][c*W +: W], win_bot[2][c*W +: W]};
        end
    end

    // line counter wraps before it reaches the image height
    assert property (@(posedge clk_in) disable iff (rst_in)
        (line_cnt < blur_pkg::line_t'(`BLUR_IMG_HEIGHT)));

endmodule

/* rtl/gaussian.sv */
// 3x3 Gaussian convolution
`timescale 1ns/1ps
`include "blur_macros.svh"

module gaussian #(
    parameter int WIDTH = `BLUR_CHAN_WIDTH
) (
    input  logic               clk_in,
    input  logic               rst_in,
    input  logic [3*WIDTH-1:0] r0_data_in,
    input  logic [3*WIDTH-1:0] r1_data_in,
    input  logic [3*WIDTH-1:0] r2_data_in,
    input  logic               data_valid_in,
    output logic [WIDTH-1:0]   data_out,
    output logic               data_valid_out
);

    // 1-2-1 / 2-4-2 / 1-2-1 in raster order, weights sum to 16
    localparam logic [WIDTH+1:0] KERNEL [9] = '{1, 2, 1, 2, 4, 2, 1, 2, 1};

    logic [WIDTH-1:0] samp [9];
    logic [WIDTH-1:0] samp_max;

    // largest product is 4x a sample, so two extra bits
    logic [WIDTH+1:0] prod_s1 [9];
    logic [WIDTH+1:0] prod_s2 [9];

    // sum of weights is 16, four extra bits
    logic [WIDTH+3:0] sum_c;
    logic [WIDTH+3:0] sum_s3;

    logic valid_s1;
    logic valid_s2;
    logic valid_s3;

    // unpack rows, leftmost sample sits in the top slice
    always_comb begin
        for (int j = 0; j < 3; j++) begin
            samp[j]     = r0_data_in[(2-j)*WIDTH +: WIDTH];
            samp[3 + j] = r1_data_in[(2-j)*WIDTH +: WIDTH];
            samp[6 + j] = r2_data_in[(2-j)*WIDTH +: WIDTH];
        end
    end

    // stage 1, weight each sample
    always_ff @(posedge clk_in) begin
        for (int i = 0; i < 9; i++) begin
            prod_s1[i] <= {2'b00, samp[i]} * KERNEL[i];
        end
    end

    // stage 2, extra register ahead of the adder tree
    always_ff @(posedge clk_in) begin
        for (int i = 0; i < 9; i++) begin
            prod_s2[i] <= prod_s1[i];
        end
    end

    // stage 3, accumulate
    always_comb begin
        sum_c = '0;
        for (int i = 0; i < 9; i++) begin
            sum_c = sum_c + {2'b00, prod_s2[i]};
        end
    end

    always_ff @(posedge clk_in) begin
        sum_s3 <= sum_c;
    end

    // stage 4, divide by 16 with truncation
    always_ff @(posedge clk_in) begin
        data_out <= sum_s3[WIDTH+3:4];
    end

    // valid travels with the data through all four stages
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            valid_s1       <= 1'b0;
            valid_s2       <= 1'b0;
            valid_s3       <= 1'b0;
            data_valid_out <= 1'b0;
        end else begin
            valid_s1       <= data_valid_in;
            valid_s2       <= valid_s1;
            valid_s3       <= valid_s2;
            data_valid_out <= valid_s3;
        end
    end

    // brightest sample of the incoming window, used only by the check below
    always_comb begin
        samp_max = samp[0];
        for (int i = 1; i < 9; i++) begin
            if (samp[i] > samp_max) begin
                samp_max = samp[i];
            end
        end
    end

    // sum cannot exceed 16x the brightest sample of the window it came from
    assert property (@(posedge clk_in) disable iff (rst_in)
        valid_s3 |-> (sum_s3 <= {$past(samp_max, 3), 4'b0000}));

endmodule

/* rtl/pixel_merge.sv */
// Channel merge and frame counter
`timescale 1ns/1ps
`include "blur_macros.svh"

module pixel_merge (
    input  logic                      clk_in,
    input  logic                      rst_in,
    input  blur_pkg::chan_t           chan_in [`BLUR_CHANNELS],
    input  logic [`BLUR_CHANNELS-1:0] chan_valid_in,
    output blur_pkg::pixel_t          pixel_out,
    output logic                      pixel_valid_out,
    output logic                      frame_done_out
);

    localparam int W = `BLUR_CHAN_WIDTH;

    // interior pixels per frame
    localparam int FRAME_PIXELS = (`BLUR_IMG_WIDTH - 2) * (`BLUR_IMG_HEIGHT - 2);

    blur_pkg::pixel_t packed_pix;
    blur_pkg::count_t out_count;
    logic             chan_valid;
    logic             last_pixel;

    // channels run in lockstep, so all valids agree
    assign chan_valid = &chan_valid_in;
    assign last_pixel = (out_count == blur_pkg::count_t'(FRAME_PIXELS - 1));

    // channel c goes back to the byte it was taken from
    always_comb begin
        for (int c = 0; c < `BLUR_CHANNELS; c++) begin
            packed_pix[c*W +: W] = chan_in[c];
        end
    end

    always_ff @(posedge clk_in) begin
        if (chan_valid) begin
            pixel_out <= packed_pix;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            pixel_valid_out <= 1'b0;
            frame_done_out  <= 1'b0;
            out_count       <= '0;
        end else begin
            pixel_valid_out <= chan_valid;
            frame_done_out  <= chan_valid && last_pixel;
            if (chan_valid) begin
                out_count <= last_pixel ? '0 : out_count + blur_pkg::count_t'(1);
            end
        end
    end

    // separate convolution pipelines must never drift apart
    assert property (@(posedge clk_in) disable iff (rst_in)
        (chan_valid_in == '0) || (&chan_valid_in));

endmodule

/* rtl/blur_top.sv */
// RGB Gaussian blur top level
`timescale 1ns/1ps
`include "blur_macros.svh"

module blur_top (
    input  logic             clk_in,
    input  logic             rst_in,
    input  blur_pkg::pixel_t pixel_in,
    input  logic             pixel_valid_in,
    output blur_pkg::pixel_t pixel_out,
    output logic             pixel_valid_out,
    output logic             frame_done_out
);

    // window rows per channel
    blur_pkg::row3_t r0 [`BLUR_CHANNELS];
    blur_pkg::row3_t r1 [`BLUR_CHANNELS];
    blur_pkg::row3_t r2 [`BLUR_CHANNELS];
    logic            window_valid;

    // blurred samples per channel
    blur_pkg::chan_t            blur_data [`BLUR_CHANNELS];
    logic [`BLUR_CHANNELS-1:0]  blur_valid;

    window_gen u_window_gen (
        .clk_in           (clk_in),
        .rst_in           (rst_in),
        .pixel_in         (pixel_in),
        .pixel_valid_in   (pixel_valid_in),
        .r0_out           (r0),
        .r1_out           (r1),
        .r2_out           (r2),
        .window_valid_out (window_valid)
    );

    // one convolution pipeline per colour channel
    for (genvar c = 0; c < `BLUR_CHANNELS; c++) begin : g_chan
        gaussian #(
            .WIDTH (`BLUR_CHAN_WIDTH)
        ) u_gaussian (
            .clk_in         (clk_in),
            .rst_in         (rst_in),
            .r0_data_in     (r0[c]),
            .r1_data_in     (r1[c]),
            .r2_data_in     (r2[c]),
            .data_valid_in  (window_valid),
            .data_out       (blur_data[c]),
            .data_valid_out (blur_valid[c])
        );
    end

    pixel_merge u_pixel_merge (
        .clk_in          (clk_in),
        .rst_in          (rst_in),
        .chan_in         (blur_data),
        .chan_valid_in   (blur_valid),
        .pixel_out       (pixel_out),
        .pixel_valid_out (pixel_valid_out),
        .frame_done_out  (frame_done_out)
    );

endmodule

/* verification/blur_tb.sv */
// Gaussian blur testbench
`timescale 1ns/1ps
`include "blur_macros.svh"

module blur_tb;

    localparam int IMG_W = `BLUR_IMG_WIDTH;
    localparam int IMG_H = `BLUR_IMG_HEIGHT;
    localparam int CW = `BLUR_CHAN_WIDTH;
    localparam int FRAME_OUT = (IMG_W - 2) * (IMG_H - 2);
    localparam int LATENCY = 6;
    localparam int N_ENTRIES = 7;

    localparam int PAT_CONST = 0;
    localparam int PAT_HRAMP = 1;
    localparam int PAT_VRAMP = 2;
    localparam int PAT_RANDOM = 3;

    // one frame per entry with its pattern, gap mode and constant colour
    localparam int PAT_TAB [N_ENTRIES] = '{PAT_CONST, PAT_HRAMP, PAT_VRAMP, PAT_RANDOM,
                                           PAT_HRAMP, PAT_RANDOM, PAT_CONST};
    localparam bit GAP_TAB [N_ENTRIES] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1};
    localparam logic [23:0] VAL_TAB [N_ENTRIES] = '{24'h8040C0, 24'h0, 24'h0, 24'h0,
                                                    24'h0, 24'h0, 24'hFF0001};

    logic             clk_in;
    logic             rst_in;
    blur_pkg::pixel_t pixel_in;
    logic             pixel_valid_in;
    blur_pkg::pixel_t pixel_out;
    logic             pixel_valid_out;
    logic             frame_done_out;

    blur_pkg::pixel_t img [IMG_H][IMG_W];
    blur_pkg::pixel_t exp_q [$];
    int               entry_q [$];
    int               in_cyc_q [$];
    logic [15:0]      lfsr;
    int               cyc;
    int               in_col;
    int               in_line;
    int               out_cnt;
    int               frames_done;
    int               error_count;
    int               check_count;
    int               frame_err_base;

    blur_top UUT (
        .clk_in          (clk_in),
        .rst_in          (rst_in),
        .pixel_in        (pixel_in),
        .pixel_valid_in  (pixel_valid_in),
        .pixel_out       (pixel_out),
        .pixel_valid_out (pixel_valid_out),
        .frame_done_out  (frame_done_out)
    );

    always #2 clk_in = ~clk_in;

    // galois form with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [23:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[22:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic string pattern_name(input int p);
        case (p)
            PAT_CONST: return "constant";
            PAT_HRAMP: return "horizontal ramp";
            PAT_VRAMP: return "vertical ramp";
            default:   return "random";
        endcase
    endfunction

    function automatic string gap_name(input bit g);
        if (g) begin
            return "with gaps";
        end
        return "continuous";
    endfunction

    // blurred sample of channel c centred on (y, x)
    function automatic blur_pkg::chan_t blur_sample(input int c, input int y, input int x);
        int sum;
        int w;
        sum = 0;
        for (int dy = -1; dy <= 1; dy++) begin
            for (int dx = -1; dx <= 1; dx++) begin
                // centre row and centre column count double
                w = (dy == 0 ? 2 : 1) * (dx == 0 ? 2 : 1);
                sum += w * int'(img[y + dy][x + dx][c*CW +: CW]);
            end
        end
        return blur_pkg::chan_t'(sum / 16);
    endfunction

    // fill the frame and queue its interior results in raster order
    task automatic make_frame(input int e);
        blur_pkg::pixel_t p;
        logic [23:0]      v;
        for (int y = 0; y < IMG_H; y++) begin
            for (int x = 0; x < IMG_W; x++) begin
                case (PAT_TAB[e])
                    PAT_CONST: img[y][x] = VAL_TAB[e];
                    PAT_HRAMP: img[y][x] = {8'(x * 16), 8'(x * 8 + 3), 8'(255 - x * 15)};
                    PAT_VRAMP: img[y][x] = {8'(y * 21), 8'(250 - y * 20), 8'(y * 7 + 1)};
                    default: begin
                        take_bits(24, v);
                        img[y][x] = v;
                    end
                endcase
            end
        end
        for (int y = 1; y < IMG_H - 1; y++) begin
            for (int x = 1; x < IMG_W - 1; x++) begin
                for (int c = 0; c < `BLUR_CHANNELS; c++) begin
                    p[c*CW +: CW] = blur_sample(c, y, x);
                end
                exp_q.push_back(p);
            end
        end
    endtask

    task automatic send_frame(input int e);
        logic [23:0] gap;
        for (int y = 0; y < IMG_H; y++) begin
            for (int x = 0; x < IMG_W; x++) begin
                @(posedge clk_in);
                pixel_in       <= img[y][x];
                pixel_valid_in <= 1'b1;
                if (GAP_TAB[e]) begin
                    take_bits(1, gap);
                    if (gap[0]) begin
                        @(posedge clk_in);
                        pixel_valid_in <= 1'b0;
                    end
                end
            end
        end
    endtask

    task automatic check_output();
        blur_pkg::pixel_t want;
        int               t_in;
        int               e;
        out_cnt++;
        check_count++;
        assert (exp_q.size() > 0) else begin
            $display("output pixel at %0t arrived with no pixel expected", $time);
            error_count++;
        end
        if (exp_q.size() > 0) begin
            want = exp_q.pop_front();
            e = entry_q[0];
            t_in = (in_cyc_q.size() > 0) ? in_cyc_q.pop_front() : -1000;
            assert (pixel_out === want) else begin
                $display("[ERROR] %0t pixel_out expected %h got %h", $time, want, pixel_out);
                error_count++;
            end
            // a flat image must come out unchanged
            if (PAT_TAB[e] == PAT_CONST) begin
                assert (pixel_out === VAL_TAB[e]) else begin
                    $display("[ERROR] %0t pixel_out expected %h got %h",
                             $time, VAL_TAB[e], pixel_out);
                    error_count++;
                end
            end
            assert (cyc - t_in == LATENCY) else begin
                $display("[ERROR] %0t pixel_valid_out latency expected %0d got %0d",
                         $time, LATENCY, cyc - t_in);
                error_count++;
            end
            assert (frame_done_out === (out_cnt == FRAME_OUT)) else begin
                $display("[ERROR] %0t frame_done_out expected %0b got %0b",
                         $time, out_cnt == FRAME_OUT, frame_done_out);
                error_count++;
            end
            if (out_cnt == FRAME_OUT) begin
                $display("frame %0d, %s, %s: %0d pixels, %0d errors", frames_done,
                         pattern_name(PAT_TAB[e]), gap_name(GAP_TAB[e]),
                         out_cnt, error_count - frame_err_base);
                frame_err_base = error_count;
                out_cnt = 0;
                frames_done++;
                void'(entry_q.pop_front());
            end
        end
    endtask

    // inputs and outputs are sampled on the falling edge
    always @(negedge clk_in) begin
        if (!rst_in) begin
            cyc++;
            if (pixel_valid_in) begin
                if (in_col >= 2 && in_line >= 2) begin
                    in_cyc_q.push_back(cyc);
                end
                if (in_col == IMG_W - 1) begin
                    in_col = 0;
                    in_line = (in_line == IMG_H - 1) ? 0 : in_line + 1;
                end else begin
                    in_col++;
                end
            end
            if (pixel_valid_out) begin
                check_output();
            end else begin
                assert (frame_done_out === 1'b0) else begin
                    $display("[ERROR] %0t frame_done_out expected 0 got %b",
                             $time, frame_done_out);
                    error_count++;
                end
            end
        end
    end

    initial begin
        int waited;
        clk_in = 1'b0;
        rst_in = 1'b1;
        pixel_in = '0;
        pixel_valid_in = 1'b0;
        lfsr = 16'd67;
        cyc = 0;
        in_col = 0;
        in_line = 0;
        out_cnt = 0;
        frames_done = 0;
        error_count = 0;
        check_count = 0;
        frame_err_base = 0;
        repeat (5) @(posedge clk_in);
        rst_in <= 1'b0;

        // nothing may come out while nothing goes in
        repeat (20) begin
            @(negedge clk_in);
            check_count++;
            assert (pixel_valid_out === 1'b0) else begin
                $display("[ERROR] %0t pixel_valid_out expected 0 got %b", $time, pixel_valid_out);
                error_count++;
            end
        end
        $display("idle after reset: %0d errors", error_count);
        frame_err_base = error_count;

        for (int e = 0; e < N_ENTRIES; e++) begin
            make_frame(e);
            entry_q.push_back(e);
            send_frame(e);
        end
        @(posedge clk_in);
        pixel_valid_in <= 1'b0;

        waited = 0;
        while (frames_done < N_ENTRIES && waited < 200) begin
            @(posedge clk_in);
            waited++;
        end
        if (frames_done < N_ENTRIES) begin
            $display("timed out waiting for all frames to leave the DUT");
            error_count++;
        end
        check_count++;
        assert (exp_q.size() == 0) else begin
            $display("%0d expected pixels never arrived", exp_q.size());
            error_count++;
        end

        $display("%0d checks, %0d errors, %0d of %0d frames", check_count, error_count,
                 frames_done, N_ENTRIES);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+include
rtl/blur_pkg.sv
rtl/window_gen.sv
rtl/gaussian.sv
rtl/pixel_merge.sv
rtl/blur_top.sv
verification/blur_tb.sv

/* run.sh */
#!/bin/sh
# build the Gaussian blur testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module blur_tb \
    -f src.f \
    -o blur_sim \
    && ./obj_dir/blur_sim | tee /dev/stderr | grep -x "test passed" > /dev/null \
    && echo "simulation PASS" \
    || { echo "simulation FAIL"; exit 1; }

exit 0
